// File: verilog/fpc_settings.svh
// Build-time sizes. FPC_RESQ_DEPTH must stay at least FPC_PIPE_STAGES + 1
`ifndef FPC_SETTINGS_SVH
`define FPC_SETTINGS_SVH

// ------------------------------------------------------------
// Architecture
// ------------------------------------------------------------
`define FPC_FLEN         32  // Single precision only
`define FPC_NUM_F_REGS   32  // f0..f31, one word each

// ------------------------------------------------------------
// Coprocessor interface
// ------------------------------------------------------------
`define FPC_ID_WIDTH     4   // Up to 16 instructions tracked by ID

// ------------------------------------------------------------
// Microarchitecture
// ------------------------------------------------------------
`define FPC_OPQ_DEPTH    4   // Accepted, waiting for commit or kill
`define FPC_PIPE_STAGES  3   // Register stages from entry to result push
`define FPC_RESQ_DEPTH   4   // Must cover every op in flight plus one

`endif

// File: verilog/fpc_isa_pkg.sv
// RV32F subset for the OP-FP opcode only; single precision fmt, no rounding mode decode
`include "fpc_settings.svh"

package fpc_isa_pkg;

  typedef logic [`FPC_FLEN-1:0] fp_word_t;
  typedef logic [$clog2(`FPC_NUM_F_REGS)-1:0] freg_idx_t;

  // IEEE 754 binary32 field view
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
  } fp_fields_t;

  localparam fp_word_t   CANONICAL_NAN = 32'h7fc00000;
  localparam logic [6:0] OPCODE_OP_FP  = 7'b1010011;

  // funct7 values with fmt = S in the low two bits
  localparam logic [6:0] F7_SGNJ   = 7'b0010000;
  localparam logic [6:0] F7_MINMAX = 7'b0010100;
  localparam logic [6:0] F7_CMP    = 7'b1010000;
  localparam logic [6:0] F7_MV_XW  = 7'b1110000;
  localparam logic [6:0] F7_MV_WX  = 7'b1111000;

  typedef enum logic [3:0] {
    OP_FSGNJ, OP_FSGNJN, OP_FSGNJX,
    OP_FMIN, OP_FMAX,
    OP_FEQ, OP_FLT, OP_FLE,
    OP_FMV_XW, OP_FMV_WX
  } fp_op_e;

  typedef struct packed {
    fp_op_e                  op;
    logic [`FPC_ID_WIDTH-1:0] id;
    freg_idx_t               rd;
    logic                    rd_is_x;   // Destination is an integer register
    freg_idx_t               rs1;
    logic                    uses_rs1;  // Scoreboard checks only real sources
    freg_idx_t               rs2;
    logic                    uses_rs2;
    logic [31:0]             int_src;   // rs1 value from the core, for FMV.W.X
  } fp_dec_op_t;

endpackage

// File: verilog/fpc_xif_pkg.sv
// eXtension-style channel types for issue, commit and result; memory channels not present
`include "fpc_settings.svh"

package fpc_xif_pkg;

  typedef logic [`FPC_ID_WIDTH-1:0] xid_t;

  typedef struct packed {
    logic [31:0] instr;  // Raw instruction word
    xid_t        id;
    logic [31:0] rs;     // Single integer source operand
  } x_issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;     // Will write an integer register
  } x_issue_resp_t;

  typedef struct packed {
    xid_t id;
    logic commit_kill;
  } x_commit_t;

  // One per committed instruction
  typedef struct packed {
    xid_t        id;
    logic [31:0] data;
    logic [4:0]  rd;
    logic        we;     // Integer register write
  } x_result_t;

endpackage

// File: verilog/fpc_op_if.sv
// Head of the operation queue toward the execute unit; valid and op hold until ready
interface fpc_op_if import fpc_isa_pkg::*; (
  input logic ck,
  input logic rst
);

  logic       valid;  // Queue not empty
  logic       ready;  // Execute takes the head this cycle
  fp_dec_op_t dec;

  modport producer (output valid, output dec, input ready);
  modport consumer (input valid, input dec, output ready);

  // A stalled head must not change under the execute unit
  a_head_stable: assert property (
    @(posedge ck) disable iff (!rst)
    valid && !ready |=> valid && $stable(dec)
  );

endinterface

// File: verilog/fpc_predecoder.sv
// Same-cycle accept decision; only the ten listed OP-FP encodings with fmt S are accepted
module fpc_predecoder import fpc_isa_pkg::*, fpc_xif_pkg::*; (
  input  logic          enable,
  input  logic          unit_ready,
  input  logic          issue_valid,
  input  x_issue_req_t  issue_req,
  input  logic          opq_full,
  output logic          issue_ready,
  output x_issue_resp_t issue_resp,
  output logic          push,
  output fp_dec_op_t    dec_op
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic [4:0] rs2_f;
  logic       known;

  assign opcode = issue_req.instr[6:0];
  assign funct3 = issue_req.instr[14:12];
  assign rs2_f  = issue_req.instr[24:20];
  assign funct7 = issue_req.instr[31:25];

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  always_comb begin
    known            = 1'b1;
    dec_op.op        = OP_FSGNJ;
    dec_op.id        = issue_req.id;
    dec_op.rd        = issue_req.instr[11:7];
    dec_op.rd_is_x   = 1'b0;
    dec_op.rs1       = issue_req.instr[19:15];
    dec_op.uses_rs1  = 1'b1;
    dec_op.rs2       = rs2_f;
    dec_op.uses_rs2  = 1'b1;
    dec_op.int_src   = issue_req.rs;
    if (opcode != OPCODE_OP_FP) begin
      known = 1'b0;
    end else begin
      case (funct7)
        F7_SGNJ: begin
          case (funct3)
            3'b000:  dec_op.op = OP_FSGNJ;
            3'b001:  dec_op.op = OP_FSGNJN;
            3'b010:  dec_op.op = OP_FSGNJX;
            default: known = 1'b0;
          endcase
        end
        F7_MINMAX: begin
          case (funct3)
            3'b000:  dec_op.op = OP_FMIN;
            3'b001:  dec_op.op = OP_FMAX;
            default: known = 1'b0;
          endcase
        end
        F7_CMP: begin
          dec_op.rd_is_x = 1'b1;  // Boolean lands in x[rd]
          case (funct3)
            3'b010:  dec_op.op = OP_FEQ;
            3'b001:  dec_op.op = OP_FLT;
            3'b000:  dec_op.op = OP_FLE;
            default: known = 1'b0;
          endcase
        end
        F7_MV_XW: begin
          dec_op.op       = OP_FMV_XW;
          dec_op.rd_is_x  = 1'b1;
          dec_op.uses_rs2 = 1'b0;
          known           = (funct3 == 3'b000) && (rs2_f == 5'd0);
        end
        F7_MV_WX: begin
          dec_op.op       = OP_FMV_WX;
          dec_op.uses_rs1 = 1'b0;  // Source is the integer operand
          dec_op.uses_rs2 = 1'b0;
          known           = (funct3 == 3'b000) && (rs2_f == 5'd0);
        end
        default: known = 1'b0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Handshake and response
  // ------------------------------------------------------------
  assign issue_ready = issue_valid && enable && unit_ready && !opq_full;
  assign issue_resp  = '{accept: issue_valid && known,
                         writeback: issue_valid && known && dec_op.rd_is_x};
  assign push        = issue_ready && issue_resp.accept;  // Accepted on this edge

endmodule

// File: verilog/fpc_queue.sv
// FIFO with combinational head; caller keeps push off when full and pop off when empty
module fpc_queue #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  logic                       ck,
  input  logic                       rst,
  input  logic                       push,
  input  payload_t                   push_data,
  input  logic                       pop,
  output payload_t                   pop_data,
  output logic                       empty,
  output logic                       full,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);

  payload_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;

  assign pop_data = mem[rd_ptr];  // Head visible while not empty
  assign empty    = (count == '0);
  assign full     = (count == ($bits(count))'(DEPTH));

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge ck or negedge rst) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;  // Wrap for any depth
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or simultaneous
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge ck) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  a_no_overflow: assert property (
    @(posedge ck) disable iff (!rst) push |-> !full
  );
  a_no_underflow: assert property (
    @(posedge ck) disable iff (!rst) pop |-> !empty
  );

endmodule

// File: verilog/fpc_execute.sv
// In-order issue, scoreboard stalls on RAW and WAW, no forwarding, no exception flags
`include "fpc_settings.svh"

module fpc_execute import fpc_isa_pkg::*, fpc_xif_pkg::*; (
  input  logic                                  ck,
  input  logic                                  rst,
  input  logic                                  enable,
  input  logic                                  commit_valid,
  input  x_commit_t                             commit,
  fpc_op_if.consumer                            op,
  input  logic [$clog2(`FPC_RESQ_DEPTH+1)-1:0] resq_count,
  output logic                                  resq_push,
  output x_result_t                             resq_data,
  output logic                                  unit_ready
);

  localparam int STAGES  = `FPC_PIPE_STAGES;
  localparam int NUM_IDS = 2 ** `FPC_ID_WIDTH;

  logic [NUM_IDS-1:0]         committed;
  logic [NUM_IDS-1:0]         killed;
  fp_word_t                   regs [`FPC_NUM_F_REGS];
  logic [`FPC_NUM_F_REGS-1:0] pending;     // Write in flight per f register
  logic [STAGES-1:0]          pipe_valid;
  x_result_t                  pipe_data [STAGES];
  fp_word_t                   src_a;
  fp_word_t                   src_b;
  logic                       head_commit;
  logic                       head_kill;
  logic                       hazard;
  logic                       room;
  logic                       consume;     // Head leaves the queue
  logic                       fire;        // Head enters the pipeline
  int unsigned                inflight;
  x_result_t                  exec_res;

  // ------------------------------------------------------------
  // Datapath helpers
  // ------------------------------------------------------------
  function automatic logic is_nan(fp_word_t x);
    fp_fields_t f;
    f = x;
    return (f.exp == 8'hff) && (f.man != '0);
  endfunction

  // Total order on non-NaN values, -0 below +0
  function automatic logic ord_lt(fp_word_t a, fp_word_t b);
    if (a[31] != b[31]) return a[31];
    if (a[31]) return a[30:0] > b[30:0];  // Both negative, larger magnitude is smaller
    return a[30:0] < b[30:0];
  endfunction

  function automatic fp_word_t min_max(fp_word_t a, fp_word_t b, logic want_max);
    if (is_nan(a) && is_nan(b)) return CANONICAL_NAN;
    if (is_nan(a)) return b;
    if (is_nan(b)) return a;
    return (ord_lt(a, b) ^ want_max) ? a : b;
  endfunction

  function automatic logic fp_cmp(fp_word_t a, fp_word_t b, fp_op_e kind);
    logic both_zero;
    logic eq;
    logic lt;
    both_zero = (a[30:0] == '0) && (b[30:0] == '0);  // +0 == -0 here
    eq        = (a == b) || both_zero;
    lt        = !both_zero && ord_lt(a, b);
    if (is_nan(a) || is_nan(b)) return 1'b0;
    case (kind)
      OP_FEQ:  return eq;
      OP_FLT:  return lt;
      default: return eq || lt;
    endcase
  endfunction

  // ------------------------------------------------------------
  // Head selection
  // ------------------------------------------------------------
  assign src_a = regs[op.dec.rs1];
  assign src_b = regs[op.dec.rs2];

  // Commit strobe counts in its own cycle
  assign head_commit = committed[op.dec.id] ||
                       (commit_valid && !commit.commit_kill && commit.id == op.dec.id);
  assign head_kill   = killed[op.dec.id] ||
                       (commit_valid && commit.commit_kill && commit.id == op.dec.id);

  assign hazard = (op.dec.uses_rs1 && pending[op.dec.rs1]) ||
                  (op.dec.uses_rs2 && pending[op.dec.rs2]) ||
                  (!op.dec.rd_is_x && pending[op.dec.rd]);

  always_comb begin
    inflight = 0;
    for (int i = 0; i < STAGES; i++) begin
      inflight += pipe_valid[i];
    end
  end

  // Room for everything already in flight plus the new one
  assign room     = (int'(resq_count) + inflight) < `FPC_RESQ_DEPTH;
  assign op.ready = unit_ready && enable && (head_kill || (head_commit && !hazard && room));
  assign consume  = op.valid && op.ready;
  assign fire     = consume && !head_kill;

  always_comb begin
    exec_res.id   = op.dec.id;
    exec_res.rd   = op.dec.rd;
    exec_res.we   = op.dec.rd_is_x;
    exec_res.data = src_a;  // FMV.X.W and fallback
    case (op.dec.op)
      OP_FSGNJ:  exec_res.data = {src_b[31], src_a[30:0]};
      OP_FSGNJN: exec_res.data = {~src_b[31], src_a[30:0]};
      OP_FSGNJX: exec_res.data = {src_a[31] ^ src_b[31], src_a[30:0]};
      OP_FMIN:   exec_res.data = min_max(src_a, src_b, 1'b0);
      OP_FMAX:   exec_res.data = min_max(src_a, src_b, 1'b1);
      OP_FEQ,
      OP_FLT,
      OP_FLE:    exec_res.data = {31'd0, fp_cmp(src_a, src_b, op.dec.op)};
      OP_FMV_WX: exec_res.data = op.dec.int_src;
      default:   exec_res.data = src_a;
    endcase
  end

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge ck or negedge rst) begin
    if (!rst) begin
      unit_ready <= 1'b0;
      committed  <= '0;
      killed     <= '0;
      pending    <= '0;
      pipe_valid <= '0;
    end else begin
      unit_ready <= 1'b1;  // Up one cycle after reset release
      if (commit_valid) begin
        if (commit.commit_kill) killed[commit.id] <= 1'b1;
        else                    committed[commit.id] <= 1'b1;
      end
      if (consume) begin  // ID free for reuse
        committed[op.dec.id] <= 1'b0;
        killed[op.dec.id]    <= 1'b0;
      end
      if (resq_push && !resq_data.we) pending[resq_data.rd] <= 1'b0;
      if (fire && !op.dec.rd_is_x)    pending[op.dec.rd]    <= 1'b1;
      pipe_valid[0] <= fire;
      for (int i = 1; i < STAGES; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
    end
  end

  // Pipeline payload and register file
  always_ff @(posedge ck) begin
    pipe_data[0] <= exec_res;
    for (int i = 1; i < STAGES; i++) begin
      pipe_data[i] <= pipe_data[i-1];
    end
    if (resq_push && !resq_data.we) begin
      regs[resq_data.rd] <= resq_data.data;  // Written at retire
    end
  end

  assign resq_push = pipe_valid[STAGES-1];
  assign resq_data = pipe_data[STAGES-1];

  a_resq_never_full: assert property (
    @(posedge ck) disable iff (!rst) resq_push |-> resq_count < `FPC_RESQ_DEPTH
  );

endmodule

// File: verilog/fpc_top.sv
// Plain eXtension-style ports; no memory channels, results return in commit order
`include "fpc_settings.svh"

module fpc_top import fpc_isa_pkg::*, fpc_xif_pkg::*; (
  input  logic          ck,
  input  logic          rst,
  input  logic          enable,
  output logic          fpu_ready,
  // Issue channel
  input  logic          issue_valid,
  output logic          issue_ready,
  input  x_issue_req_t  issue_req,
  output x_issue_resp_t issue_resp,
  // Commit channel
  input  logic          commit_valid,
  input  x_commit_t     commit,
  // Result channel
  output logic          result_valid,
  input  logic          result_ready,
  output x_result_t     result
);

  fp_dec_op_t                               opq_in;
  logic                                     opq_push;
  logic                                     opq_full;
  logic                                     opq_empty;
  logic                                     resq_push;
  x_result_t                                resq_data;
  logic                                     resq_empty;
  logic [$clog2(`FPC_RESQ_DEPTH+1)-1:0]    resq_count;

  fpc_op_if op_if (.ck(ck), .rst(rst));

  fpc_predecoder predecoder_i (
    .enable(enable), .unit_ready(fpu_ready), .issue_valid(issue_valid),
    .issue_req(issue_req), .opq_full(opq_full), .issue_ready(issue_ready),
    .issue_resp(issue_resp), .push(opq_push), .dec_op(opq_in)
  );

  // Operation queue, head goes straight onto op_if
  fpc_queue #(.payload_t(fp_dec_op_t), .DEPTH(`FPC_OPQ_DEPTH)) opq_i (
    .ck(ck), .rst(rst), .push(opq_push), .push_data(opq_in),
    .pop(op_if.valid && op_if.ready), .pop_data(op_if.dec),
    .empty(opq_empty), .full(opq_full), .count()
  );
  assign op_if.valid = !opq_empty;

  fpc_execute execute_i (
    .ck(ck), .rst(rst), .enable(enable), .commit_valid(commit_valid),
    .commit(commit), .op(op_if.consumer), .resq_count(resq_count),
    .resq_push(resq_push), .resq_data(resq_data), .unit_ready(fpu_ready)
  );

  // Result queue drains on the result handshake
  fpc_queue #(.payload_t(x_result_t), .DEPTH(`FPC_RESQ_DEPTH)) resq_i (
    .ck(ck), .rst(rst), .push(resq_push), .push_data(resq_data),
    .pop(result_valid && result_ready), .pop_data(result),
    .empty(resq_empty), .full(), .count(resq_count)
  );
  assign result_valid = !resq_empty;

endmodule

// File: verification/tb_fpc_top.sv
// Run from the project root so the trace path resolves; results are checked in commit order
module tb_fpc_top import fpc_xif_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic          ck;
  logic          rst;
  logic          enable;
  logic          fpu_ready;
  logic          issue_valid;
  logic          issue_ready;
  x_issue_req_t  issue_req;
  x_issue_resp_t issue_resp;
  logic          commit_valid;
  x_commit_t     commit;
  logic          result_valid;
  logic          result_ready;
  x_result_t     result;

  string       trace_lines[$];
  x_result_t   exp_q[$];       // Expected results, commit order
  int unsigned cycles;
  int unsigned limit;

  fpc_top fpc_top_i (.*);

  // ------------------------------------------------------------
  // Clock, watchdog and random back-pressure
  // ------------------------------------------------------------
  initial begin
    ck = 1'b0;
    forever #2 ck = ~ck;  // 4 ns period
  end

  always @(posedge ck) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, DUT stopped responding", cycles);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  initial begin
    result_ready = 1'b0;
    void'($urandom(32'h5feb));  // One seed for the whole run
    forever begin
      @(posedge ck);
      #1 result_ready = ($urandom % 4) != 0;  // High about 3 of 4 cycles
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  function automatic string format_result(input x_result_t r);
    return $sformatf("id %0h data %h rd %0h we %b", r.id, r.data, r.rd, r.we);
  endfunction

  task automatic compare_status(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic compare_issue_resp(input x_issue_resp_t got, input x_issue_resp_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t issue_resp got %b expected %b", $time, got, exp));
    end
  endtask

  task automatic compare_result(input x_result_t got, input x_result_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t result got %s expected %s",
                         $time, format_result(got), format_result(exp)));
    end
  endtask

  // Results are sampled at the falling edge, before the handshake edge
  always @(negedge ck) begin
    if (rst && result_valid && result_ready) begin
      if (exp_q.size() == 0) begin
        stop_run($sformatf("Unexpected result with id %0h at %0t", result.id, $time));
      end else begin
        compare_result(result, exp_q.pop_front());
      end
    end
  end

  // ------------------------------------------------------------
  // Channel drivers, entered and left 1 ns after a rising edge
  // ------------------------------------------------------------
  task automatic do_issue(input logic [31:0] instr, input xid_t id, input logic [31:0] rs,
                          input x_issue_resp_t exp);
    issue_valid    = 1'b1;
    issue_req.instr = instr;
    issue_req.id   = id;
    issue_req.rs   = rs;
    @(negedge ck);
    while (!issue_ready) begin  // Queue full, wait for room
      @(posedge ck);
      #1;
      @(negedge ck);
    end
    compare_issue_resp(issue_resp, exp);
    @(posedge ck);
    #1 issue_valid = 1'b0;
  endtask

  task automatic do_commit(input xid_t id, input logic kill);
    commit_valid       = 1'b1;
    commit.id          = id;
    commit.commit_kill = kill;
    @(posedge ck);
    #1 commit_valid = 1'b0;  // One-cycle strobe
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int            fd;
    int            n;
    string         line;
    string         kind;
    logic [31:0]   f[10];
    x_issue_resp_t exp_resp;
    x_result_t     exp_res;
    cycles       = 0;
    limit        = 0;
    rst          = 1'b0;
    enable       = 1'b1;
    issue_valid  = 1'b0;
    issue_req    = '0;
    commit_valid = 1'b0;
    commit       = '0;
    fd = $fopen("verification/fpc_trace.txt", "r");
    if (fd == 0) stop_run("Cannot open the trace file verification/fpc_trace.txt");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") trace_lines.push_back(line);
    end
    $fclose(fd);
    limit = 40 * trace_lines.size();  // 40 cycles per trace line
    repeat (8) @(posedge ck);
    #1;
    compare_status("fpu_ready", fpu_ready, 1'b0);  // Still held in reset
    rst = 1'b1;
    @(posedge ck);
    #1;
    // One cycle after release the unit is up and both channels are idle
    compare_status("fpu_ready", fpu_ready, 1'b1);
    compare_status("issue_ready", issue_ready, 1'b0);
    compare_status("result_valid", result_valid, 1'b0);
    foreach (trace_lines[i]) begin
      n = $sscanf(trace_lines[i], "%s %h %h %h %h %h %h %h %h %h %h", kind,
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
      if (kind == "I") begin
        // f7 rs2 rs1 f3 rd opcode id rs accept writeback
        exp_resp = '{accept: f[8][0], writeback: f[9][0]};
        do_issue({f[0][6:0], f[1][4:0], f[2][4:0], f[3][2:0], f[4][4:0], f[5][6:0]},
                 xid_t'(f[6]), f[7], exp_resp);
      end else if (kind == "C") begin
        // id kill data rd we
        if (!f[1][0]) begin
          exp_res = '{id: xid_t'(f[0]), data: f[2], rd: f[3][4:0], we: f[4][0]};
          exp_q.push_back(exp_res);
        end
        do_commit(xid_t'(f[0]), f[1][0]);
      end else begin
        stop_run($sformatf("Trace line not understood: %s", trace_lines[i]));
      end
    end
    while (exp_q.size() != 0) @(posedge ck);
    repeat (20) @(posedge ck);  // Catch stray results
    if (!result_valid) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("Results left over at the end of the run");
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

endmodule

// File: verification/fpc_trace.txt
# I f7 rs2 rs1 f3 rd opcode id rs accept writeback  (hex, issue with expected response)
# C id kill data rd we  (hex, commit strobe then expected result unless killed)
I 00 00 00 0 00 33 0 00000000 0 0
I 78 00 00 0 01 53 1 3f800000 1 0
C 1 0 3f800000 01 0
I 78 00 00 0 02 53 2 c0000000 1 0
C 2 0 c0000000 02 0
I 78 00 00 0 03 53 3 7fa00000 1 0
C 3 0 7fa00000 03 0
I 78 00 00 0 04 53 4 00000000 1 0
C 4 0 00000000 04 0
I 78 00 00 0 05 53 5 80000000 1 0
C 5 0 80000000 05 0
I 78 00 00 0 06 53 6 40400000 1 0
C 6 0 40400000 06 0
I 70 00 02 0 0a 53 7 00000000 1 1
C 7 0 c0000000 0a 1
I 10 02 01 0 07 53 8 00000000 1 0
C 8 0 bf800000 07 0
I 10 02 02 1 08 53 9 00000000 1 0
C 9 0 40000000 08 0
I 10 02 06 2 09 53 a 00000000 1 0
C a 0 c0400000 09 0
I 14 02 01 0 0a 53 b 00000000 1 0
C b 0 c0000000 0a 0
I 14 03 01 1 0b 53 c 00000000 1 0
C c 0 3f800000 0b 0
I 14 05 04 0 0c 53 d 00000000 1 0
C d 0 80000000 0c 0
I 14 03 03 1 0d 53 e 00000000 1 0
C e 0 7fc00000 0d 0
I 50 05 04 2 0b 53 f 00000000 1 1
C f 0 00000001 0b 1
I 50 01 02 1 0c 53 0 00000000 1 1
C 0 0 00000001 0c 1
I 50 01 03 0 0d 53 1 00000000 1 1
C 1 0 00000000 0d 1
I 50 04 05 1 0e 53 2 00000000 1 1
C 2 0 00000000 0e 1
I 50 04 05 0 0f 53 3 00000000 1 1
C 3 0 00000001 0f 1
I 78 00 00 0 01 53 4 12345678 1 0
C 4 1 00000000 00 0
I 70 00 01 0 10 53 5 00000000 1 1
C 5 0 3f800000 10 1
I 10 06 06 1 0e 53 6 00000000 1 0
I 14 01 0e 1 0f 53 7 00000000 1 0
I 70 00 0f 0 11 53 8 00000000 1 1
C 6 0 c0400000 0e 0
C 7 0 3f800000 0f 0
C 8 0 3f800000 11 1

// File: compile.f
+incdir+verilog
verilog/fpc_isa_pkg.sv
verilog/fpc_xif_pkg.sv
verilog/fpc_op_if.sv
verilog/fpc_predecoder.sv
verilog/fpc_queue.sv
verilog/fpc_execute.sv
verilog/fpc_top.sv
verification/tb_fpc_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_fpc_top

out=$(./obj_dir/Vtb_fpc_top) || true
echo "$out"

if grep -q "ALL CHECKS PASSED" <<< "$out"; then
  exit 0
fi
exit 1
